//--- list.f
spi_reg_pkg.sv
spi_byte_link.sv
spi_word_link.sv
spi_cmd_agent.sv
reg_arbiter.sv
reg_memory.sv
spi_reg_top.sv
tb_spi_reg.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the SPI register port testbench with Verilator

rm -rf obj_dir sim.log build.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_spi_reg \
  -f list.f > build.log 2>&1 &&
./obj_dir/Vtb_spi_reg > sim.log 2>&1

grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

//--- tb_spi_reg.sv
// Self-checking testbench for the SPI register port with an SPI controller model and a local port
module tb_spi_reg;

  // Controller timing in clk cycles
  localparam int CLK_PERIOD = 4;
  localparam int HALF = 8;
  localparam int GAP = 16;
  localparam int XFER_CLKS = 2 * HALF * 64 + 2 * HALF + GAP + 4;
  // Full transfers issued by all tests together
  localparam int XFER_COUNT = 15;
  localparam int WATCHDOG_TIME = (XFER_COUNT * XFER_CLKS + 2000) * CLK_PERIOD;
  localparam int LOC_MAX_WAIT = 6;

  logic clk;
  logic resetn;
  logic sck;
  logic cs_n;
  logic copi;
  logic cipo;
  logic loc_req;
  logic loc_we;
  spi_reg_pkg::addr_t loc_addr;
  spi_reg_pkg::data_t loc_wdata;
  spi_reg_pkg::data_t loc_rdata;
  logic loc_done;

  // Expected memory contents and the reply due in the next transfer
  spi_reg_pkg::data_t model [spi_reg_pkg::MEM_DEPTH];
  spi_reg_pkg::word_t exp_reply;
  logic [31:0] lfsr;

  int errors = 0;
  int checks = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_errors_start = 0;
  int loc_done_seen = 0;

  // Raised on the SCK fall that ends a transfer
  event last_fall;

  spi_reg_top uut (
    .clk       (clk),
    .resetn    (resetn),
    .sck       (sck),
    .cs_n      (cs_n),
    .copi      (copi),
    .cipo      (cipo),
    .loc_req   (loc_req),
    .loc_we    (loc_we),
    .loc_addr  (loc_addr),
    .loc_wdata (loc_wdata),
    .loc_rdata (loc_rdata),
    .loc_done  (loc_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Counts local done pulses, one cycle each
  always @(negedge clk) begin
    if (!resetn && loc_done) begin
      loc_done_seen++;
    end
  end

  // A done pulse only answers a pending local request
  assert property (@(posedge clk) disable iff (resetn) loc_done |-> loc_req)
    else begin
      errors++;
      $display("loc_done pulsed without a pending local request at time %0t", $time);
    end

  initial begin
    #(WATCHDOG_TIME);
    $display("Watchdog expired at time %0t before the tests finished", $time);
    $display("Checks failed");
    $finish;
  end

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    logic fb;
    int i;
    r = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r = {r[30:0], fb};
    end
    return r;
  endfunction

  // Opcode, address, two zero bytes, data
  function automatic spi_reg_pkg::word_t make_word(input spi_reg_pkg::byte_t op,
                                                   input spi_reg_pkg::addr_t addr,
                                                   input spi_reg_pkg::data_t data);
    return {data, 16'h0000, addr, op};
  endfunction

  // Bytes go out in order, each MSB first
  function automatic int bit_pos(input int i);
    return (i / 8) * 8 + 7 - (i % 8);
  endfunction

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_true(input string what, input logic cond);
    checks++;
    assert (cond === 1'b1) else begin
      errors++;
      $display("At time %0t the condition '%s' did not hold", $time, what);
    end
  endtask

  // Mode 0 controller, cipo sampled mid-cycle just before each rising SCK
  task automatic spi_xfer(input spi_reg_pkg::word_t mosi, input int nbits,
                          output spi_reg_pkg::word_t miso);
    int i;
    int idx;
    miso = '0;
    @(posedge clk);
    cs_n <= 1'b0;
    repeat (HALF) @(posedge clk);
    for (i = 0; i < nbits; i++) begin
      idx = bit_pos(i);
      @(posedge clk);
      sck <= 1'b0;
      copi <= mosi[idx];
      repeat (HALF - 1) @(posedge clk);
      @(negedge clk);
      miso[idx] = cipo;
      @(posedge clk);
      sck <= 1'b1;
      repeat (HALF - 1) @(posedge clk);
    end
    @(posedge clk);
    sck <= 1'b0;
    -> last_fall;
    repeat (HALF) @(posedge clk);
    cs_n <= 1'b1;
    repeat (GAP) @(posedge clk);
  endtask

  // Full command transfer, its reply answers the previous command
  task automatic spi_cmd(input spi_reg_pkg::byte_t op, input spi_reg_pkg::addr_t addr,
                         input spi_reg_pkg::data_t data);
    spi_reg_pkg::word_t got;
    spi_xfer(make_word(op, addr, data), 64, got);
    check_value("SPI reply", got, exp_reply);
    if (op == spi_reg_pkg::OP_WRITE) begin
      model[addr] = data;
      exp_reply = make_word(op, addr, data);
    end else if (op == spi_reg_pkg::OP_READ) begin
      exp_reply = make_word(op, addr, model[addr]);
    end
  endtask

  // Request level held until the done pulse, dropped on the next edge
  task automatic loc_access(input logic we, input spi_reg_pkg::addr_t addr,
                            input spi_reg_pkg::data_t data, output spi_reg_pkg::data_t rdata);
    int lat;
    lat = 0;
    @(posedge clk);
    loc_req <= 1'b1;
    loc_we <= we;
    loc_addr <= addr;
    loc_wdata <= data;
    @(negedge clk);
    while (!loc_done && lat < 20) begin
      @(negedge clk);
      lat++;
    end
    rdata = loc_rdata;
    check_true("local done within 6 clk of the request", loc_done && (lat <= LOC_MAX_WAIT));
    if (we) begin
      model[addr] = data;
    end
    @(posedge clk);
    loc_req <= 1'b0;
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_errors_start) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name,
               errors - test_errors_start);
    end
    test_errors_start = errors;
  endtask

  initial begin
    spi_reg_pkg::word_t got;
    spi_reg_pkg::data_t rd;
    spi_reg_pkg::addr_t a2;
    spi_reg_pkg::addr_t a3;
    spi_reg_pkg::addr_t a4;
    spi_reg_pkg::addr_t a5;
    spi_reg_pkg::addr_t a6;
    int count0;
    resetn = 1'b1;
    sck = 1'b0;
    cs_n = 1'b1;
    copi = 1'b0;
    loc_req = 1'b0;
    loc_we = 1'b0;
    loc_addr = '0;
    loc_wdata = '0;
    lfsr = 32'hf697;
    exp_reply = '0;
    repeat (4) @(posedge clk);
    resetn <= 1'b0;

    // Idle local port and a zero reply word
    repeat (8) begin
      @(negedge clk);
      check_true("loc_done low after reset", !loc_done);
    end
    spi_cmd(spi_reg_pkg::OP_NOP, 8'h00, 32'h0);
    finish_test("reset state");

    // Read reply shows up in the NOP after the read
    a2 = spi_reg_pkg::addr_t'(rand_bits(8));
    spi_cmd(spi_reg_pkg::OP_WRITE, a2, rand_bits(32));
    spi_cmd(spi_reg_pkg::OP_READ, a2, 32'h0);
    spi_cmd(spi_reg_pkg::OP_NOP, 8'h00, 32'h0);
    finish_test("SPI write and read");

    a3 = spi_reg_pkg::addr_t'(rand_bits(8));
    loc_access(1'b1, a3, rand_bits(32), rd);
    spi_cmd(spi_reg_pkg::OP_READ, a3, 32'h0);
    spi_cmd(spi_reg_pkg::OP_WRITE, a3, rand_bits(32));
    spi_cmd(spi_reg_pkg::OP_NOP, 8'h00, 32'h0);
    finish_test("local write then SPI read");

    a4 = spi_reg_pkg::addr_t'(rand_bits(8));
    spi_cmd(spi_reg_pkg::OP_WRITE, a4, rand_bits(32));
    loc_access(1'b0, a4, 32'h0, rd);
    check_value("local read data", rd, model[a4]);
    finish_test("SPI write then local read");

    // Local request lands in the cycle spi_req rises, 5 clk after the last fall
    a5 = spi_reg_pkg::addr_t'(rand_bits(8));
    count0 = loc_done_seen;
    fork
      spi_cmd(spi_reg_pkg::OP_WRITE, a5, rand_bits(32));
      begin
        @(last_fall);
        repeat (4) @(posedge clk);
        loc_access(1'b1, a5 ^ 8'h80, rand_bits(32), rd);
      end
    join
    check_true("exactly one loc_done pulse", (loc_done_seen - count0) == 1);
    spi_cmd(spi_reg_pkg::OP_READ, a5 ^ 8'h80, 32'h0);
    spi_cmd(spi_reg_pkg::OP_NOP, 8'h00, 32'h0);
    loc_access(1'b0, a5, 32'h0, rd);
    check_value("local read data", rd, model[a5]);
    finish_test("simultaneous requests");

    // Aborted write to a2 after 11 bits must leave memory and reply alone
    a6 = a2 ^ 8'h40;
    spi_xfer(make_word(spi_reg_pkg::OP_WRITE, a2, rand_bits(32)), 11, got);
    spi_cmd(spi_reg_pkg::OP_WRITE, a6, rand_bits(32));
    spi_cmd(spi_reg_pkg::OP_READ, a6, 32'h0);
    spi_cmd(spi_reg_pkg::OP_NOP, 8'h00, 32'h0);
    loc_access(1'b0, a2, 32'h0, rd);
    check_value("local read data", rd, model[a2]);
    finish_test("CS release mid transfer");

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

//--- spi_reg_top.sv
// SPI register port top that joins the SPI path and the local port on one word memory
module spi_reg_top (
  input  logic               clk,
  input  logic               resetn,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               copi,
  output logic               cipo,
  input  logic               loc_req,
  input  logic               loc_we,
  input  spi_reg_pkg::addr_t loc_addr,
  input  spi_reg_pkg::data_t loc_wdata,
  output spi_reg_pkg::data_t loc_rdata,
  output logic               loc_done
);

  // SPI word path
  spi_reg_pkg::word_t rx_word;
  spi_reg_pkg::word_t tx_word;
  logic word_valid;

  // SPI requester
  logic spi_req;
  logic spi_we;
  spi_reg_pkg::addr_t spi_addr;
  spi_reg_pkg::data_t spi_wdata;
  spi_reg_pkg::data_t spi_rdata;
  logic spi_done;

  // Memory port
  logic mem_en;
  logic mem_we;
  spi_reg_pkg::addr_t mem_addr;
  spi_reg_pkg::data_t mem_wdata;
  spi_reg_pkg::data_t mem_rdata;

  spi_word_link u_word_link (
    .clk        (clk),
    .resetn     (resetn),
    .sck        (sck),
    .cs_n       (cs_n),
    .copi       (copi),
    .cipo       (cipo),
    .tx_word    (tx_word),
    .rx_word    (rx_word),
    .word_valid (word_valid)
  );

  spi_cmd_agent u_cmd_agent (
    .clk        (clk),
    .resetn     (resetn),
    .rx_word    (rx_word),
    .word_valid (word_valid),
    .spi_done   (spi_done),
    .spi_rdata  (spi_rdata),
    .spi_req    (spi_req),
    .spi_we     (spi_we),
    .spi_addr   (spi_addr),
    .spi_wdata  (spi_wdata),
    .tx_word    (tx_word)
  );

  // Local port and SPI agent are peers
  reg_arbiter u_arbiter (
    .clk       (clk),
    .resetn    (resetn),
    .spi_req   (spi_req),
    .spi_we    (spi_we),
    .spi_addr  (spi_addr),
    .spi_wdata (spi_wdata),
    .spi_done  (spi_done),
    .spi_rdata (spi_rdata),
    .loc_req   (loc_req),
    .loc_we    (loc_we),
    .loc_addr  (loc_addr),
    .loc_wdata (loc_wdata),
    .loc_done  (loc_done),
    .loc_rdata (loc_rdata),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

  reg_memory u_memory (
    .clk       (clk),
    .mem_en    (mem_en),
    .mem_we    (mem_we),
    .mem_addr  (mem_addr),
    .mem_wdata (mem_wdata),
    .mem_rdata (mem_rdata)
  );

endmodule

//--- reg_memory.sv
// Single-port word memory with a registered read one cycle after the access
module reg_memory (
  input  logic               clk,
  input  logic               mem_en,
  input  logic               mem_we,
  input  spi_reg_pkg::addr_t mem_addr,
  input  spi_reg_pkg::data_t mem_wdata,
  output spi_reg_pkg::data_t mem_rdata
);

  // Storage array
  spi_reg_pkg::data_t mem [spi_reg_pkg::MEM_DEPTH];

  // Write port
  always_ff @(posedge clk) begin
    if (mem_en && mem_we) begin
      mem[mem_addr] <= mem_wdata;
    end
  end

  // Read port
  // Output holds its value between reads
  always_ff @(posedge clk) begin
    if (mem_en && !mem_we) begin
      mem_rdata <= mem[mem_addr];
    end
  end

endmodule

//--- reg_arbiter.sv
// Round-robin arbiter between the SPI agent and the local port in front of the memory
module reg_arbiter (
  input  logic               clk,
  input  logic               resetn,
  input  logic               spi_req,
  input  logic               spi_we,
  input  spi_reg_pkg::addr_t spi_addr,
  input  spi_reg_pkg::data_t spi_wdata,
  output logic               spi_done,
  output spi_reg_pkg::data_t spi_rdata,
  input  logic               loc_req,
  input  logic               loc_we,
  input  spi_reg_pkg::addr_t loc_addr,
  input  spi_reg_pkg::data_t loc_wdata,
  output logic               loc_done,
  output spi_reg_pkg::data_t loc_rdata,
  output logic               mem_en,
  output logic               mem_we,
  output spi_reg_pkg::addr_t mem_addr,
  output spi_reg_pkg::data_t mem_wdata,
  input  spi_reg_pkg::data_t mem_rdata
);

  spi_reg_pkg::arb_state_t state;
  // Set when the local port had the last grant
  logic last_loc;
  logic spi_want;
  logic loc_want;

  // A requester still holds req in its done cycle
  assign spi_want = spi_req && !spi_done;
  assign loc_want = loc_req && !loc_done;

  always_ff @(posedge clk) begin
    if (resetn) begin
      state <= spi_reg_pkg::ARB_IDLE;
      last_loc <= 1'b0;
      spi_done <= 1'b0;
      loc_done <= 1'b0;
    end else begin
      // Done lands one cycle after the access with the read data
      spi_done <= (state == spi_reg_pkg::ARB_SPI);
      loc_done <= (state == spi_reg_pkg::ARB_LOC);
      case (state)
        spi_reg_pkg::ARB_IDLE: begin
          // On a tie the peer not served last wins
          if (spi_want && (!loc_want || last_loc)) begin
            state <= spi_reg_pkg::ARB_SPI;
            last_loc <= 1'b0;
          end else if (loc_want) begin
            state <= spi_reg_pkg::ARB_LOC;
            last_loc <= 1'b1;
          end
        end
        // One access per grant
        default: state <= spi_reg_pkg::ARB_IDLE;
      endcase
    end
  end

  // Memory port follows the granted requester
  always_comb begin
    mem_en = 1'b0;
    mem_we = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    case (state)
      spi_reg_pkg::ARB_SPI: begin
        mem_en = 1'b1;
        mem_we = spi_we;
        mem_addr = spi_addr;
        mem_wdata = spi_wdata;
      end
      spi_reg_pkg::ARB_LOC: begin
        mem_en = 1'b1;
        mem_we = loc_we;
        mem_addr = loc_addr;
        mem_wdata = loc_wdata;
      end
      default: begin
      end
    endcase
  end

  // Registered read data is valid in the done cycle
  assign spi_rdata = mem_rdata;
  assign loc_rdata = mem_rdata;

  // Each done pulse answers a request that is still held
  assert property (@(posedge clk) disable iff (resetn)
    spi_done |-> spi_req);
  assert property (@(posedge clk) disable iff (resetn)
    loc_done |-> loc_req);

endmodule

//--- spi_cmd_agent.sv
// SPI command agent that turns transfer words into memory requests and builds reply words
module spi_cmd_agent (
  input  logic               clk,
  input  logic               resetn,
  input  spi_reg_pkg::word_t rx_word,
  input  logic               word_valid,
  input  logic               spi_done,
  input  spi_reg_pkg::data_t spi_rdata,
  output logic               spi_req,
  output logic               spi_we,
  output spi_reg_pkg::addr_t spi_addr,
  output spi_reg_pkg::data_t spi_wdata,
  output spi_reg_pkg::word_t tx_word
);

  // Fields of the incoming word
  spi_reg_pkg::byte_t rx_op;
  // Opcode of the pending command for the echo
  spi_reg_pkg::byte_t op;
  spi_reg_pkg::data_t reply_data;
  logic cmd_hit;

  assign rx_op = rx_word[7:0];

  // Only write and read reach the arbiter
  // NOP leaves the request and the reply untouched
  // A word in the done cycle takes over from the finished command
  assign cmd_hit = word_valid && (!spi_req || spi_done) &&
    ((rx_op == spi_reg_pkg::OP_WRITE) || (rx_op == spi_reg_pkg::OP_READ));

  // Request held from the cycle after the word until done
  always_ff @(posedge clk) begin
    if (resetn) begin
      spi_req <= 1'b0;
    end else if (cmd_hit) begin
      spi_req <= 1'b1;
    end else if (spi_done) begin
      spi_req <= 1'b0;
    end
  end

  // Command fields stay stable while the request is up
  always_ff @(posedge clk) begin
    if (cmd_hit) begin
      op <= rx_op;
      spi_addr <= rx_word[15:8];
      spi_wdata <= rx_word[63:32];
      spi_we <= (rx_op == spi_reg_pkg::OP_WRITE);
    end
  end

  // Write echoes its own data and read returns the memory word
  assign reply_data = spi_we ? spi_wdata : spi_rdata;

  // Reply word in the command layout
  // Shifted out during the next transfer
  always_ff @(posedge clk) begin
    if (resetn) begin
      tx_word <= '0;
    end else if (spi_done) begin
      tx_word <= {reply_data, 16'h0000, spi_addr, op};
    end
  end

  // SCK spacing keeps a new word from landing on a pending command
  assert property (@(posedge clk) disable iff (resetn)
    word_valid |-> !spi_req || spi_done);

endmodule

//--- spi_word_link.sv
// SPI word link that gathers eight bytes into one transfer word and serves the reply bytes
module spi_word_link (
  input  logic               clk,
  input  logic               resetn,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               copi,
  output logic               cipo,
  input  spi_reg_pkg::word_t tx_word,
  output spi_reg_pkg::word_t rx_word,
  output logic               word_valid
);

  // Byte level link
  spi_reg_pkg::byte_t rx_byte;
  spi_reg_pkg::byte_t tx_byte;
  logic rx_valid;
  logic active;

  // Byte position inside the current transfer
  spi_reg_pkg::byte_cnt_t byte_cnt;
  logic last_byte;

  spi_byte_link u_byte_link (
    .clk      (clk),
    .resetn   (resetn),
    .sck      (sck),
    .cs_n     (cs_n),
    .copi     (copi),
    .cipo     (cipo),
    .tx_byte  (tx_byte),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .active   (active)
  );

  assign last_byte =
    (byte_cnt == spi_reg_pkg::byte_cnt_t'(spi_reg_pkg::WORD_BYTES - 1));

  // Byte count and word pulse
  always_ff @(posedge clk) begin
    if (resetn) begin
      byte_cnt <= '0;
      word_valid <= 1'b0;
    end else begin
      word_valid <= 1'b0;
      if (rx_valid) begin
        // Wraps modulo WORD_BYTES
        byte_cnt <= byte_cnt + 1'b1;
        word_valid <= last_byte;
      end else if (!active) begin
        // CS release throws away a partial word
        byte_cnt <= '0;
      end
    end
  end

  // Little endian assembly
  // New bytes enter at the top so the first one ends in bits 7:0
  always_ff @(posedge clk) begin
    if (rx_valid) begin
      rx_word <= {rx_byte, rx_word[spi_reg_pkg::WORD_W-1:8]};
    end
  end

  // Outgoing byte follows the same little endian order
  assign tx_byte = tx_word[{byte_cnt, 3'b000} +: 8];

  // A word completes only on the wrap of the byte count while CS is still active
  assert property (@(posedge clk) disable iff (resetn)
    word_valid |-> active && (byte_cnt == '0));

endmodule

//--- spi_byte_link.sv
// SPI mode 0 byte peripheral that shifts one byte in and one byte out per eight SCK cycles
module spi_byte_link (
  input  logic               clk,
  input  logic               resetn,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               copi,
  output logic               cipo,
  input  spi_reg_pkg::byte_t tx_byte,
  output spi_reg_pkg::byte_t rx_byte,
  output logic               rx_valid,
  output logic               active
);

  // Pin synchronizers
  // SCK keeps one more stage so that edges come from the synchronized history
  logic [2:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] copi_sync;

  // Received bits count up on rising SCK
  spi_reg_pkg::bit_cnt_t rx_cnt;
  // Sent bits count down on falling SCK
  spi_reg_pkg::bit_cnt_t tx_cnt;

  logic sck_rise;
  logic sck_fall;
  logic copi_bit;

  // Edges seen one stage after the synchronized value
  assign sck_rise = sck_sync[1] & ~sck_sync[2];
  assign sck_fall = ~sck_sync[1] & sck_sync[2];

  // CS is active low on the pin
  assign active = ~cs_sync[1];
  assign copi_bit = copi_sync[1];

  // Always driven from the current bit index
  assign cipo = tx_byte[tx_cnt];

  // Synchronous reset asserted high
  always_ff @(posedge clk) begin
    if (resetn) begin
      // Mode 0 idles with SCK low and CS released
      sck_sync <= '0;
      cs_sync <= '1;
      copi_sync <= '0;
    end else begin
      sck_sync <= {sck_sync[1:0], sck};
      cs_sync <= {cs_sync[0], cs_n};
      copi_sync <= {copi_sync[0], copi};
    end
  end

  // Bit counters and end of byte pulse
  always_ff @(posedge clk) begin
    if (resetn) begin
      rx_cnt <= '0;
      tx_cnt <= '1;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (!active) begin
        // Released CS drops any partial byte
        rx_cnt <= '0;
        tx_cnt <= '1;
      end else if (sck_rise) begin
        rx_cnt <= rx_cnt + 1'b1;
      end else if (sck_fall) begin
        tx_cnt <= tx_cnt - 1'b1;
        // Falling edge after bit 0 closes the byte
        rx_valid <= (tx_cnt == '0);
      end
    end
  end

  // Receive shift register
  // COPI is sampled MSB first on rising SCK
  always_ff @(posedge clk) begin
    if (active && sck_rise) begin
      rx_byte <= {rx_byte[6:0], copi_bit};
    end
  end

  // A finished byte arrives with CS still active and a full set of rising edges
  assert property (@(posedge clk) disable iff (resetn)
    rx_valid |-> active && (rx_cnt == '0));

endmodule

//--- spi_reg_pkg.sv
// Shared widths, opcodes and arbiter states for the SPI register port
package spi_reg_pkg;

  // Transfer geometry
  localparam int WORD_BYTES = 8;
  localparam int WORD_W = WORD_BYTES * 8;
  localparam int BYTE_CNT_W = $clog2(WORD_BYTES);
  localparam int BIT_CNT_W = 3;

  // Number of memory words
  localparam int MEM_DEPTH = 256;

  // Width types
  typedef logic [7:0] byte_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [31:0] data_t;
  typedef logic [7:0] addr_t;
  typedef logic [BIT_CNT_W-1:0] bit_cnt_t;
  typedef logic [BYTE_CNT_W-1:0] byte_cnt_t;

  // Opcode byte in bits 7:0 of a transfer
  localparam byte_t OP_NOP = 8'h00;
  localparam byte_t OP_WRITE = 8'h01;
  localparam byte_t OP_READ = 8'h02;

  // Arbiter FSM
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_SPI,
    ARB_LOC
  } arb_state_t;

endpackage
